// File: hw/atop_pkg.sv
// -----------------------------------------------
// Atomic resolver shared definitions
// Bus widths and the OBI atomic opcode encoding
// -----------------------------------------------

`default_nettype none

package atop_pkg;

  // -----------------------------------------------
  // Bus widths
  // -----------------------------------------------

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // -----------------------------------------------
  // Atomic opcodes
  // -----------------------------------------------

  // Bit 5 marks an atomic, LR and SC are the two non-AMO codes among them
  typedef enum logic [5:0] {
    ATOPNONE = 6'h00,
    AMOADD   = 6'h20,
    AMOSWAP  = 6'h21,
    ATOPLR   = 6'h22,
    ATOPSC   = 6'h23,
    AMOXOR   = 6'h24,
    AMOOR    = 6'h28,
    AMOAND   = 6'h2C,
    AMOMIN   = 6'h30,
    AMOMAX   = 6'h34,
    AMOMINU  = 6'h38,
    AMOMAXU  = 6'h3C
  } atop_e;

endpackage

`default_nettype wire

// File: hw/amo_alu.sv
// -----------------------------------------------
// AMO ALU
// Computes the value written back by an AMO from
// the old memory word and the request operand
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module amo_alu (
  input  atop_pkg::atop_e                op_i,
  input  logic [atop_pkg::DataWidth-1:0] operand_a_i,
  input  logic [atop_pkg::DataWidth-1:0] operand_b_i,
  output logic [atop_pkg::DataWidth-1:0] result_o
);

  import atop_pkg::*;

  logic                 sext;
  logic                 sub;
  logic                 a_lt_b;
  logic [DataWidth:0]   ext_a;
  logic [DataWidth:0]   ext_b;
  logic [DataWidth:0]   adder_sum;

  // Signed compares extend with the sign bit, unsigned ones with zero
  assign sext = op_i inside {AMOMIN, AMOMAX};
  assign sub  = op_i inside {AMOMIN, AMOMAX, AMOMINU, AMOMAXU};

  assign ext_a = {sext & operand_a_i[DataWidth-1], operand_a_i};
  assign ext_b = {sext & operand_b_i[DataWidth-1], operand_b_i};

  // One adder for add and for a - b, the carry-in completes the negation
  assign adder_sum = ext_a + (sub ? ~ext_b : ext_b) + {{DataWidth{1'b0}}, sub};

  // The top bit of the extended difference is the sign of a - b
  assign a_lt_b = adder_sum[DataWidth];

  always_comb begin
    unique case (op_i)
      AMOSWAP: result_o = operand_b_i;
      AMOADD:  result_o = adder_sum[DataWidth-1:0];
      AMOXOR:  result_o = operand_a_i ^ operand_b_i;
      AMOAND:  result_o = operand_a_i & operand_b_i;
      AMOOR:   result_o = operand_a_i | operand_b_i;
      AMOMIN:  result_o = a_lt_b ? operand_a_i : operand_b_i;
      AMOMINU: result_o = a_lt_b ? operand_a_i : operand_b_i;
      AMOMAX:  result_o = a_lt_b ? operand_b_i : operand_a_i;
      AMOMAXU: result_o = a_lt_b ? operand_b_i : operand_a_i;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/lrsc_reservation.sv
// -----------------------------------------------
// LR/SC reservation tracking
// Holds one reservation and decides SC success
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lrsc_reservation (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           take_i,
  input  logic [atop_pkg::AddrWidth-1:0] addr_i,
  input  logic [atop_pkg::IdWidth-1:0]   aid_i,
  input  atop_pkg::atop_e                atop_i,
  input  logic                           we_i,
  output logic                           sc_we_o,
  output logic                           sc_q_o,
  output logic                           success_q_o
);

  import atop_pkg::*;

  logic                 res_valid_q, res_valid_d;
  logic [AddrWidth-1:0] res_addr_q, res_addr_d;
  logic [IdWidth-1:0]   res_id_q, res_id_d;
  logic                 success_d;
  logic                 is_store;

  // Anything that may modify memory counts as a store for the reservation
  assign is_store = we_i || (atop_i == ATOPSC) ||
                    (atop_i[5] && !(atop_i inside {ATOPLR, ATOPSC}));

  // An SC writes only while its own reservation on that address is intact
  assign sc_we_o = (atop_i == ATOPSC) && res_valid_q &&
                   (res_id_q == aid_i) && (res_addr_q == addr_i);

  always_comb begin
    res_valid_d = res_valid_q;
    res_addr_d  = res_addr_q;
    res_id_d    = res_id_q;
    success_d   = 1'b0;
    if (take_i) begin
      // Another ID cannot steal a live reservation, which avoids live-lock
      if (atop_i == ATOPLR && (!res_valid_q || res_id_q == aid_i)) begin
        res_valid_d = 1'b1;
        res_addr_d  = addr_i;
        res_id_d    = aid_i;
        success_d   = 1'b1;
      end
      if (aid_i != res_id_q && addr_i == res_addr_q && is_store) begin
        res_valid_d = 1'b0;
      end
      // Any SC from the owner ends the reservation, matching or not
      if (res_valid_q && atop_i == ATOPSC && res_id_q == aid_i) begin
        res_valid_d = 1'b0;
        success_d   = sc_we_o;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
      res_addr_q  <= '0;
      res_id_q    <= '0;
      success_q_o <= 1'b0;
      sc_q_o      <= 1'b0;
    end else begin
      res_valid_q <= res_valid_d;
      res_addr_q  <= res_addr_d;
      res_id_q    <= res_id_d;
      success_q_o <= success_d;
      sc_q_o      <= take_i && (atop_i == ATOPSC);
    end
  end

endmodule

`default_nettype wire

// File: hw/amo_sequencer.sv
// -----------------------------------------------
// AMO sequencer
// Splits an AMO into a read and a locked write,
// passes every other request through
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module amo_sequencer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic [atop_pkg::AddrWidth-1:0] addr_i,
  input  logic                           we_i,
  input  logic [atop_pkg::BeWidth-1:0]   be_i,
  input  logic [atop_pkg::DataWidth-1:0] wdata_i,
  input  logic [atop_pkg::IdWidth-1:0]   aid_i,
  input  atop_pkg::atop_e                atop_i,
  input  logic                           gnt_i,
  input  logic                           rvalid_i,
  input  logic [atop_pkg::DataWidth-1:0] rdata_i,
  input  logic                           buf_ready_i,
  input  logic                           sc_we_i,
  output logic                           gnt_o,
  output logic                           take_o,
  output logic                           req_o,
  output logic [atop_pkg::AddrWidth-1:0] addr_o,
  output logic                           we_o,
  output logic [atop_pkg::BeWidth-1:0]   be_o,
  output logic [atop_pkg::DataWidth-1:0] wdata_o,
  output logic [atop_pkg::IdWidth-1:0]   aid_o,
  output logic                           wb_pending_o
);

  import atop_pkg::*;

  typedef enum logic {
    Idle,
    DoAMO
  } state_e;

  state_e               state_q, state_d;
  logic                 is_amo;
  logic                 load_amo;
  logic                 wb_pending_q;
  atop_e                op_q;
  logic [AddrWidth-1:0] addr_q;
  logic [IdWidth-1:0]   aid_q;
  logic [DataWidth-1:0] operand_a_q;
  logic [DataWidth-1:0] operand_b_q;
  logic [DataWidth-1:0] operand_a;
  logic [DataWidth-1:0] amo_result;

  assign is_amo = atop_i[5] && !(atop_i inside {ATOPLR, ATOPSC});

  // The subordinate side is held off for the whole AMO
  assign gnt_o  = buf_ready_i && gnt_i && (state_q == Idle);
  assign take_o = req_i && gnt_o;

  // The old value is live on rvalid_i in the first DoAMO cycle only
  assign operand_a    = rvalid_i ? rdata_i : operand_a_q;
  assign wb_pending_o = wb_pending_q;

  amo_alu u_amo_alu (
    .op_i        (op_q),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b_q),
    .result_o    (amo_result)
  );

  always_comb begin
    state_d  = state_q;
    load_amo = 1'b0;
    req_o    = req_i && buf_ready_i;
    addr_o   = addr_i;
    be_o     = be_i;
    wdata_o  = wdata_i;
    aid_o    = aid_i;
    if (atop_i == ATOPSC) begin
      we_o = sc_we_i;
    end else if (atop_i == ATOPLR || is_amo) begin
      we_o = 1'b0;
    end else begin
      we_o = we_i;
    end
    unique case (state_q)
      Idle: begin
        if (take_o && is_amo) begin
          load_amo = 1'b1;
          state_d  = DoAMO;
        end
      end
      // Write back the ALU result until the memory grants it
      DoAMO: begin
        req_o   = 1'b1;
        we_o    = 1'b1;
        addr_o  = addr_q;
        aid_o   = aid_q;
        be_o    = {BeWidth{1'b1}};
        wdata_o = amo_result;
        if (gnt_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      op_q         <= ATOPNONE;
      wb_pending_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // The response to a granted writeback arrives in the next cycle
      wb_pending_q <= (state_q == DoAMO) && gnt_i;
      if (load_amo) begin
        op_q <= atop_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q      <= addr_i;
      aid_q       <= aid_i;
      operand_b_q <= wdata_i;
    end
    if (rvalid_i) begin
      operand_a_q <= rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/resp_buffer.sv
// -----------------------------------------------
// Response buffer
// Pairs granted IDs with returned data and keeps
// both in order under rready back-pressure
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module resp_buffer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           take_i,
  input  logic [atop_pkg::IdWidth-1:0]   aid_i,
  input  logic                           rvalid_i,
  input  logic [atop_pkg::DataWidth-1:0] rdata_i,
  input  logic                           err_i,
  input  logic                           sc_q_i,
  input  logic                           success_q_i,
  input  logic                           drop_i,
  input  logic                           rready_i,
  output logic                           buf_ready_o,
  output logic                           rvalid_o,
  output logic [atop_pkg::DataWidth-1:0] rdata_o,
  output logic [atop_pkg::IdWidth-1:0]   rid_o,
  output logic                           err_o,
  output logic                           exokay_o
);

  import atop_pkg::*;

  logic [IdWidth-1:0]   id_mem [2];
  logic                 id_wptr, id_rptr;
  logic [1:0]           id_cnt;
  logic [DataWidth+1:0] dat_mem [2];
  logic [DataWidth+1:0] entry_in, entry_out;
  logic [DataWidth-1:0] resp_data;
  logic                 dat_wptr, dat_rptr;
  logic [1:0]           dat_cnt;
  logic                 dat_empty, dat_push, dat_wr, dat_rd, pop;

  // An SC reports 0 on success and 1 on failure instead of memory data
  assign resp_data = sc_q_i ? {{(DataWidth-1){1'b0}}, !success_q_i} : rdata_i;
  assign entry_in  = {success_q_i, err_i, resp_data};

  // Data FIFO is fall-through, so a response leaves in the cycle it arrives
  assign dat_push  = rvalid_i && !drop_i;
  assign dat_empty = (dat_cnt == 2'd0);
  assign entry_out = dat_empty ? entry_in : dat_mem[dat_rptr];
  assign dat_wr    = dat_push && !(dat_empty && pop);
  assign dat_rd    = pop && !dat_empty;

  assign buf_ready_o = dat_empty;
  assign rvalid_o    = (id_cnt != 2'd0) && (dat_push || !dat_empty);
  assign pop         = rvalid_o && rready_i;
  assign rid_o       = id_mem[id_rptr];
  assign exokay_o    = entry_out[DataWidth+1];
  assign err_o       = entry_out[DataWidth];
  assign rdata_o     = entry_out[DataWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_wptr  <= 1'b0;
      id_rptr  <= 1'b0;
      id_cnt   <= 2'd0;
      dat_wptr <= 1'b0;
      dat_rptr <= 1'b0;
      dat_cnt  <= 2'd0;
    end else begin
      id_wptr  <= id_wptr ^ take_i;
      id_rptr  <= id_rptr ^ pop;
      id_cnt   <= id_cnt + {1'b0, take_i} - {1'b0, pop};
      dat_wptr <= dat_wptr ^ dat_wr;
      dat_rptr <= dat_rptr ^ dat_rd;
      dat_cnt  <= dat_cnt + {1'b0, dat_wr} - {1'b0, dat_rd};
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_i) begin
      id_mem[id_wptr] <= aid_i;
    end
    if (dat_wr) begin
      dat_mem[dat_wptr] <= entry_in;
    end
  end

endmodule

`default_nettype wire

// File: hw/atop_resolver.sv
// -----------------------------------------------
// Atomic operation resolver
// Resolves OBI atomics and LR/SC in front of a
// single-port memory without atomic support
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module atop_resolver (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Subordinate side
  input  logic                           req_i,
  input  logic [atop_pkg::AddrWidth-1:0] addr_i,
  input  logic                           we_i,
  input  logic [atop_pkg::BeWidth-1:0]   be_i,
  input  logic [atop_pkg::DataWidth-1:0] wdata_i,
  input  logic [atop_pkg::IdWidth-1:0]   aid_i,
  input  atop_pkg::atop_e                atop_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [atop_pkg::DataWidth-1:0] rdata_o,
  output logic [atop_pkg::IdWidth-1:0]   rid_o,
  output logic                           err_o,
  output logic                           exokay_o,
  input  logic                           rready_i,
  // Manager side
  output logic                           req_o,
  output logic [atop_pkg::AddrWidth-1:0] addr_o,
  output logic                           we_o,
  output logic [atop_pkg::BeWidth-1:0]   be_o,
  output logic [atop_pkg::DataWidth-1:0] wdata_o,
  output logic [atop_pkg::IdWidth-1:0]   aid_o,
  input  logic                           gnt_i,
  input  logic                           rvalid_i,
  input  logic [atop_pkg::DataWidth-1:0] rdata_i,
  input  logic                           err_i
);

  logic take, buf_ready, wb_pending;
  logic sc_we, sc_q, success_q;

  lrsc_reservation u_lrsc_reservation (
    .clk_i, .rst_ni, .take_i (take), .addr_i, .aid_i, .atop_i, .we_i,
    .sc_we_o (sc_we), .sc_q_o (sc_q), .success_q_o (success_q)
  );

  amo_sequencer u_amo_sequencer (
    .clk_i, .rst_ni, .req_i, .addr_i, .we_i, .be_i, .wdata_i, .aid_i, .atop_i,
    .gnt_i, .rvalid_i, .rdata_i, .buf_ready_i (buf_ready), .sc_we_i (sc_we),
    .gnt_o, .take_o (take), .req_o, .addr_o, .we_o, .be_o, .wdata_o, .aid_o,
    .wb_pending_o (wb_pending)
  );

  // Writeback responses of an AMO never reach the subordinate side
  resp_buffer u_resp_buffer (
    .clk_i, .rst_ni, .take_i (take), .aid_i, .rvalid_i, .rdata_i, .err_i,
    .sc_q_i (sc_q), .success_q_i (success_q), .drop_i (wb_pending), .rready_i,
    .buf_ready_o (buf_ready), .rvalid_o, .rdata_o, .rid_o, .err_o, .exokay_o
  );

endmodule

`default_nettype wire

// File: tests/tb_memory.sv
// -----------------------------------------------
// Testbench memory model
// Single-port word memory with an externally
// driven grant, one-cycle response, error window
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_memory (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           gnt_en_i,
  input  logic                           req_i,
  input  logic [atop_pkg::AddrWidth-1:0] addr_i,
  input  logic                           we_i,
  input  logic [atop_pkg::BeWidth-1:0]   be_i,
  input  logic [atop_pkg::DataWidth-1:0] wdata_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [atop_pkg::DataWidth-1:0] rdata_o,
  output logic                           err_o
);

  import atop_pkg::*;

  localparam int unsigned Depth    = 64;
  localparam int unsigned ErrFirst = 56;

  logic [DataWidth-1:0] mem [Depth];
  logic [5:0]           idx;

  assign idx   = addr_i[7:2];
  assign gnt_o = gnt_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      // Every word starts with a value unique to its index
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= 32'h9e37_79b9 * (i + 1);
      end
    end else begin
      rvalid_o <= req_i && gnt_o;
      if (req_i && gnt_o) begin
        rdata_o <= mem[idx];
        err_o   <= (idx >= ErrFirst);
        // Words in the error window never change
        if (we_i && idx < ErrFirst) begin
          for (int b = 0; b < BeWidth; b++) begin
            if (be_i[b]) begin
              mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_atop_resolver.sv
// -----------------------------------------------
// Atomic resolver testbench
// Random OBI traffic with AMOs and LR/SC, checked
// against a mirror memory and reservation model
// -----------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_atop_resolver;

  import atop_pkg::*;

  localparam logic [31:0] Seed        = 32'ha9c8;
  localparam int          Depth       = 64;
  localparam int          ErrFirst    = 56;
  localparam int          NumPlain    = 40;
  localparam int          AmoRounds   = 3;
  localparam int          LrscRounds  = 4;
  localparam int          NumConflict = 8;
  localparam int          NumRandom   = 80;
  localparam int          NumErr      = 16;
  localparam int          TotalReqs   = NumPlain + 18 * AmoRounds + 5 * LrscRounds +
                                        NumConflict + NumRandom + NumErr;
  localparam int          TimeoutCycles = 20 * TotalReqs;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 err;
    logic                 exokay;
    logic                 chk_data;
  } resp_t;

  logic                 clk_i, rst_ni;
  logic                 req_i, we_i, rready_i;
  logic [AddrWidth-1:0] addr_i;
  logic [BeWidth-1:0]   be_i;
  logic [DataWidth-1:0] wdata_i;
  logic [IdWidth-1:0]   aid_i;
  atop_e                atop_i;
  logic                 gnt_o, rvalid_o, err_o, exokay_o;
  logic [DataWidth-1:0] rdata_o;
  logic [IdWidth-1:0]   rid_o;

  logic                 mgr_req, mgr_we, mgr_gnt, mgr_rvalid, mgr_err, mem_gnt;
  logic [AddrWidth-1:0] mgr_addr;
  logic [BeWidth-1:0]   mgr_be;
  logic [DataWidth-1:0] mgr_wdata, mgr_rdata;
  logic [IdWidth-1:0]   mgr_aid;

  // Reference model state
  logic [DataWidth-1:0] mirror [Depth];
  logic                 res_valid;
  logic [5:0]           res_idx;
  logic [IdWidth-1:0]   res_id;
  resp_t                exp_q [$];
  resp_t                head;

  // ID expected on the writeback of a granted AMO
  logic                 wb_armed;
  logic [IdWidth-1:0]   wb_id;

  logic [31:0] lfsr_q;
  logic        bp_mode, held;
  int          stretch, errors, n_checks, n_req, req_mark, err_mark, cycles;
  atop_e       amo_ops [9] = '{AMOADD, AMOSWAP, AMOXOR, AMOAND, AMOOR,
                               AMOMIN, AMOMAX, AMOMINU, AMOMAXU};

  atop_resolver u_atop_resolver (
    .clk_i, .rst_ni, .req_i, .addr_i, .we_i, .be_i, .wdata_i, .aid_i, .atop_i,
    .gnt_o, .rvalid_o, .rdata_o, .rid_o, .err_o, .exokay_o, .rready_i,
    .req_o (mgr_req), .addr_o (mgr_addr), .we_o (mgr_we), .be_o (mgr_be),
    .wdata_o (mgr_wdata), .aid_o (mgr_aid), .gnt_i (mgr_gnt),
    .rvalid_i (mgr_rvalid), .rdata_i (mgr_rdata), .err_i (mgr_err)
  );

  tb_memory u_tb_memory (
    .clk_i, .rst_ni, .gnt_en_i (mem_gnt), .req_i (mgr_req), .addr_i (mgr_addr),
    .we_i (mgr_we), .be_i (mgr_be), .wdata_i (mgr_wdata), .gnt_o (mgr_gnt),
    .rvalid_o (mgr_rvalid), .rdata_o (mgr_rdata), .err_o (mgr_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic logic [DataWidth-1:0] expected_amo(input atop_e op,
      input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
    case (op)
      AMOADD:  return a + b;
      AMOSWAP: return b;
      AMOXOR:  return a ^ b;
      AMOAND:  return a & b;
      AMOOR:   return a | b;
      AMOMIN:  return ($signed(a) < $signed(b)) ? a : b;
      AMOMAX:  return ($signed(a) > $signed(b)) ? a : b;
      AMOMINU: return (a < b) ? a : b;
      AMOMAXU: return (a > b) ? a : b;
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Each falling edge drops the request and draws grant and rready
  task automatic step_cycle();
    @(negedge clk_i);
    req_i   = 1'b0;
    mem_gnt = (rand_bits(2) != 0);
    if (bp_mode) begin
      if (stretch == 0) begin
        rready_i = next_bit();
        stretch  = rand_bits(5);
      end else begin
        stretch--;
      end
    end else begin
      rready_i = 1'b1;
    end
  endtask

  // Hold the request until granted, then apply it to the model
  task automatic issue_request(input atop_e op, input logic we, input logic [5:0] idx,
      input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] wdata,
      input logic [IdWidth-1:0] id);
    resp_t                e;
    logic [DataWidth-1:0] old;
    logic                 win, is_amo, store, sc_ok;
    step_cycle();
    req_i   = 1'b1;
    addr_i  = {24'h0, idx, 2'b00};
    we_i    = we;
    be_i    = be;
    wdata_i = wdata;
    aid_i   = id;
    atop_i  = op;
    @(posedge clk_i);
    while (!gnt_o) begin
      step_cycle();
      req_i = 1'b1;
      @(posedge clk_i);
    end
    old    = mirror[idx];
    win    = (idx >= ErrFirst);
    is_amo = op[5] && !(op inside {ATOPLR, ATOPSC});
    store  = we || is_amo || (op == ATOPSC);
    sc_ok  = (op == ATOPSC) && res_valid && (res_id == id) && (res_idx == idx);
    e.id       = id;
    e.data     = old;
    e.err      = win;
    e.exokay   = 1'b0;
    e.chk_data = !win && (!we || is_amo);
    // A store by another ID breaks the reservation on that word
    if (store && res_valid && res_id != id && res_idx == idx) begin
      res_valid = 1'b0;
    end
    if (op == ATOPLR && (!res_valid || res_id == id)) begin
      res_valid = 1'b1;
      res_idx   = idx;
      res_id    = id;
      e.exokay  = 1'b1;
    end
    if (op == ATOPSC) begin
      if (res_valid && res_id == id) begin
        res_valid = 1'b0;
      end
      e.exokay   = sc_ok;
      e.data     = {31'b0, !sc_ok};
      e.chk_data = 1'b1;
    end
    if (!win && is_amo) begin
      mirror[idx] = expected_amo(op, old, wdata);
    end else if (!win && ((op == ATOPNONE && we) || sc_ok)) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (be[b]) begin
          mirror[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
    exp_q.push_back(e);
    n_req++;
  endtask

  task automatic end_test(input string name);
    while (exp_q.size() != 0) begin
      step_cycle();
    end
    $display("test %s done: %0d requests, %0d errors", name, n_req - req_mark,
             errors - err_mark);
    req_mark = n_req;
    err_mark = errors;
  endtask

  task automatic run_plain();
    logic [5:0]           idx;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wd;
    logic [IdWidth-1:0]   id;
    for (int i = 0; i < NumPlain; i++) begin
      idx = rand_bits(6) % ErrFirst;
      we  = next_bit();
      be  = rand_bits(4);
      wd  = rand_bits(32);
      id  = rand_bits(4);
      issue_request(ATOPNONE, we, idx, be, wd, id);
    end
  endtask

  task automatic run_amo();
    logic [5:0]           idx;
    logic [DataWidth-1:0] wd;
    logic [IdWidth-1:0]   id;
    for (int r = 0; r < AmoRounds; r++) begin
      for (int k = 0; k < 9; k++) begin
        idx = rand_bits(6) % ErrFirst;
        wd  = rand_bits(32);
        id  = rand_bits(4);
        issue_request(amo_ops[k], 1'b1, idx, 4'hf, wd, id);
        // The read back shows the value the ALU wrote
        id = rand_bits(4);
        issue_request(ATOPNONE, 1'b0, idx, 4'hf, '0, id);
      end
    end
  endtask

  task automatic run_lrsc();
    logic [5:0]           idx;
    logic [DataWidth-1:0] wd;
    logic [IdWidth-1:0]   id;
    for (int r = 0; r < LrscRounds; r++) begin
      idx = rand_bits(6) % ErrFirst;
      wd  = rand_bits(32);
      id  = rand_bits(4);
      issue_request(ATOPLR, 1'b0, idx, 4'hf, '0, id);
      issue_request(ATOPSC, 1'b1, idx, 4'hf, wd, id);
      issue_request(ATOPNONE, 1'b0, idx, 4'hf, '0, id);
      // The reservation is gone, so this SC must fail
      wd = rand_bits(32);
      issue_request(ATOPSC, 1'b1, idx, 4'hf, wd, id);
      issue_request(ATOPNONE, 1'b0, idx, 4'hf, '0, id);
    end
  endtask

  task automatic run_conflict();
    logic [5:0]           x, y;
    logic [IdWidth-1:0]   ida, idb;
    logic [DataWidth-1:0] wd;
    x   = rand_bits(6) % ErrFirst;
    y   = x ^ 6'd1;
    ida = rand_bits(4);
    idb = ida + 1'b1;
    wd  = rand_bits(32);
    issue_request(ATOPLR, 1'b0, x, 4'hf, '0, ida);
    issue_request(ATOPNONE, 1'b1, x, 4'hf, wd, idb);
    wd = rand_bits(32);
    issue_request(ATOPSC, 1'b1, x, 4'hf, wd, ida);
    issue_request(ATOPNONE, 1'b0, x, 4'hf, '0, ida);
    issue_request(ATOPLR, 1'b0, y, 4'hf, '0, ida);
    issue_request(ATOPLR, 1'b0, y, 4'hf, '0, idb);
    wd = rand_bits(32);
    issue_request(ATOPSC, 1'b1, y, 4'hf, wd, ida);
    issue_request(ATOPNONE, 1'b0, y, 4'hf, '0, idb);
  endtask

  task automatic run_random();
    logic [3:0]           sel;
    logic [5:0]           idx;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wd;
    logic [IdWidth-1:0]   id;
    for (int i = 0; i < NumRandom; i++) begin
      // Few words and few IDs so reservations collide often
      sel = rand_bits(4);
      idx = rand_bits(3);
      be  = rand_bits(4);
      wd  = rand_bits(32);
      id  = rand_bits(2);
      if (sel < 6) begin
        issue_request(ATOPNONE, sel[0], idx, be, wd, id);
      end else if (sel == 6) begin
        issue_request(ATOPLR, 1'b0, idx, 4'hf, '0, id);
      end else if (sel == 7) begin
        issue_request(ATOPSC, 1'b1, idx, 4'hf, wd, id);
      end else begin
        issue_request(amo_ops[sel - 8], 1'b1, idx, 4'hf, wd, id);
      end
    end
  endtask

  task automatic run_errors();
    logic [5:0]           idx;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wd;
    logic [IdWidth-1:0]   id;
    for (int i = 0; i < NumErr; i++) begin
      if (i % 2 == 0) begin
        idx = ErrFirst + rand_bits(3);
      end else begin
        idx = rand_bits(6) % ErrFirst;
      end
      we = next_bit();
      be = rand_bits(4);
      wd = rand_bits(32);
      id = rand_bits(4);
      issue_request(ATOPNONE, we, idx, be, wd, id);
    end
  endtask

  // ------------------------------------------------
  // Response monitor
  // ------------------------------------------------

  always @(posedge clk_i) begin
    if (rst_ni) begin
      assert (!(held && gnt_o)) else begin
        $display("gnt_o was high at %0t while a response waited in the buffer", $time);
        errors++;
      end
      held = rvalid_o && !rready_i;
      // A passed-through request keeps its ID and a writeback carries the AMO's ID
      if (mgr_req && mgr_gnt) begin
        if (wb_armed) begin
          check_value("aid_o", mgr_aid, wb_id);
          wb_armed = 1'b0;
        end else begin
          check_value("aid_o", mgr_aid, aid_i);
        end
      end
      if (req_i && gnt_o && atop_i[5] && !(atop_i inside {ATOPLR, ATOPSC})) begin
        wb_armed = 1'b1;
        wb_id    = aid_i;
      end
      if (rvalid_o && rready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("response at %0t with rid %h has no outstanding request", $time, rid_o);
          errors++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check_value("rid_o", rid_o, head.id);
          check_value("err_o", err_o, head.err);
          check_value("exokay_o", exokay_o, head.exokay);
          if (head.chk_data) begin
            check_value("rdata_o", rdata_o, head.data);
          end
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d responses outstanding", cycles, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    lfsr_q    = Seed;
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    addr_i    = '0;
    we_i      = 1'b0;
    be_i      = '0;
    wdata_i   = '0;
    aid_i     = '0;
    atop_i    = ATOPNONE;
    rready_i  = 1'b1;
    mem_gnt   = 1'b0;
    bp_mode   = 1'b0;
    held      = 1'b0;
    wb_armed  = 1'b0;
    wb_id     = '0;
    stretch   = 0;
    errors    = 0;
    n_checks  = 0;
    n_req     = 0;
    req_mark  = 0;
    err_mark  = 0;
    res_valid = 1'b0;
    res_idx   = '0;
    res_id    = '0;
    // Same fill as the memory model applies at reset
    for (int i = 0; i < Depth; i++) begin
      mirror[i] = 32'h9e37_79b9 * (i + 1);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    run_plain();
    end_test("plain");
    run_amo();
    end_test("amo");
    run_lrsc();
    end_test("lrsc");
    run_conflict();
    end_test("conflict");
    bp_mode = 1'b1;
    run_random();
    end_test("backpressure");
    bp_mode = 1'b0;
    run_errors();
    end_test("error_window");

    $display("summary: %0d requests, %0d checks, %0d errors", n_req, n_checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/atop_pkg.sv
hw/amo_alu.sv
hw/lrsc_reservation.sv
hw/amo_sequencer.sv
hw/resp_buffer.sv
hw/atop_resolver.sv
tests/tb_memory.sv
tests/tb_atop_resolver.sv

// File: Bender.yml
package:
  name: atop_resolver

sources:
  - files:
      - hw/atop_pkg.sv
      - hw/amo_alu.sv
      - hw/lrsc_reservation.sv
      - hw/amo_sequencer.sv
      - hw/resp_buffer.sv
      - hw/atop_resolver.sv
  - target: test
    files:
      - tests/tb_memory.sv
      - tests/tb_atop_resolver.sv
